/* src/icache_cfg_pkg.sv */
// instruction cache configuration
// geometry constants, address field types and controller states
`default_nettype none

package icache_cfg_pkg;

  // geometry: two ways, sixteen sets, 16-byte lines
  localparam int unsigned NUM_WAYS    = 2;
  localparam int unsigned NUM_SETS    = 16;
  // upper half of the address space is I/O
  localparam int unsigned NC_ADDR_BIT = 31;
  // nonzero start value for the replacement lfsr
  localparam logic [7:0]  LFSR_SEED   = 8'hA5;

  // physical fetch address
  typedef logic [31:0] paddr_t;
  // address bits 31..8
  typedef logic [23:0] tag_t;
  // address bits 7..4
  typedef logic [3:0]  set_idx_t;
  // word within the line, bits 3..2
  typedef logic [1:0]  word_off_t;

  typedef logic [31:0]  fetch_word_t;
  typedef logic [127:0] line_t;

  // one bit per way, and a binary way number
  typedef logic [1:0] way_vec_t;
  typedef logic [0:0] way_idx_t;

  // controller states
  typedef enum logic [1:0] {
    IDLE,
    READ,
    MISS,
    FLUSH
  } ctrl_state_e;

endpackage

`default_nettype wire

/* src/icache_mem_pkg.sv */
// instruction cache memory side
// fill request, return packet and return kind
`default_nettype none

package icache_mem_pkg;

  import icache_cfg_pkg::*;

  // what a return packet carries
  typedef enum logic {
    IFILL_ACK,
    INV_REQ
  } rtrn_kind_e;

  // invalidation of one way or of all ways in a set
  typedef struct packed {
    set_idx_t idx;
    way_idx_t way;
    logic     vld;
    logic     all;
  } inv_t;

  // return packet, a whole line per beat
  typedef struct packed {
    rtrn_kind_e kind;
    line_t      data;
    inv_t       inv;
  } mem_rtrn_t;

  // fill request towards memory
  typedef struct packed {
    paddr_t   paddr;
    logic     nc;
    way_idx_t way;
  } fill_req_t;

endpackage

`default_nettype wire

/* src/icache_fetch_in.sv */
// instruction cache input side
// holds the accepted fetch address and splits it into its fields
`timescale 1ns/1ps
`default_nettype none

module icache_fetch_in import icache_cfg_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire logic      req_i,
  input  wire logic      ready_i,
  input  wire paddr_t    addr_i,
  input  wire logic      cache_en_i,
  output tag_t           tag_o,
  output set_idx_t       set_o,
  output word_off_t      off_o,
  output logic           nc_o,
  output set_idx_t       rd_set_o
);

  paddr_t addr_q;
  logic   accept;

  // handshake with the fetch unit
  assign accept = req_i & ready_i;

  // latch the address in case we stall on a miss
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_addr
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (accept) begin
      addr_q <= addr_i;
    end
  end

  // array read index bypasses the register on accept
  assign rd_set_o = accept ? addr_i[7:4] : addr_q[7:4];

  // fields of the held address
  assign tag_o = addr_q[31:8];
  assign set_o = addr_q[7:4];
  assign off_o = addr_q[3:2];

  // I/O space or disabled cache goes the non-cacheable way
  assign nc_o = ~cache_en_i | addr_q[NC_ADDR_BIT];

endmodule

`default_nettype wire

/* src/icache_ctrl.sv */
// instruction cache controller
// request/refill FSM, enable and pending-flush tracking, flush sweep
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl import icache_cfg_pkg::*, icache_mem_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       en_i,
  input  wire logic       flush_i,
  input  wire logic       req_i,
  input  wire logic       hit_i,
  input  wire logic       nc_i,
  input  wire logic       fill_ack_i,
  input  wire logic       rtrn_vld_i,
  input  wire rtrn_kind_e rtrn_kind_i,
  output logic            ready_o,
  output logic            valid_o,
  output logic            fill_req_o,
  output logic            miss_o,
  output logic            rd_en_o,
  output logic            wr_en_o,
  output logic            inv_en_o,
  output logic            flush_en_o,
  output set_idx_t        flush_set_o,
  output logic            cmp_en_o,
  output logic            cache_en_o
);

  ctrl_state_e state_d, state_q;
  logic        cache_en_d, cache_en_q;
  logic        flush_d, flush_q;
  logic        cmp_en_d, cmp_en_q;
  set_idx_t    flush_cnt_q;
  logic        flush_done;
  logic        fill_rtrn;

  // invalidations are taken in any state, never together with a fill
  assign inv_en_o  = rtrn_vld_i & (rtrn_kind_i == INV_REQ);
  assign fill_rtrn = rtrn_vld_i & (rtrn_kind_i == IFILL_ACK);

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d    = state_q;
    // switching off is immediate, switching on goes via FLUSH
    cache_en_d = cache_en_q & en_i;
    flush_d    = flush_q | flush_i;
    cmp_en_d   = 1'b0;
    ready_o    = 1'b0;
    valid_o    = 1'b0;
    fill_req_o = 1'b0;
    miss_o     = 1'b0;
    rd_en_o    = 1'b0;
    wr_en_o    = 1'b0;
    flush_en_o = 1'b0;

    unique case (state_q)
      // wait for a request
      IDLE: begin
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else if (!rtrn_vld_i) begin
          ready_o = 1'b1;
          if (req_i) begin
            rd_en_o  = 1'b1;
            cmp_en_d = cache_en_q;
            state_d  = READ;
          end
        end
      end
      // tag compare; nc and disabled accesses fall into the miss path
      READ: begin
        if (hit_i) begin
          state_d = IDLE;
          // a pending flush drops the hit
          if (!flush_d) begin
            valid_o = 1'b1;
            // back to back requests, unless an invalidation comes in
            if (!rtrn_vld_i) begin
              ready_o = 1'b1;
              if (req_i) begin
                rd_en_o  = 1'b1;
                cmp_en_d = cache_en_q;
                state_d  = READ;
              end
            end
          end
        end else begin
          // hold the fill request until acknowledged
          fill_req_o = 1'b1;
          if (fill_ack_i) begin
            // count only real misses
            miss_o  = ~nc_i;
            state_d = MISS;
          end
        end
      end
      // wait for the line, always consumed
      MISS: begin
        if (fill_rtrn) begin
          state_d = IDLE;
          if (!flush_d) begin
            valid_o = 1'b1;
            wr_en_o = ~nc_i;
          end
        end
      end
      // sweep all sets, one per cycle
      FLUSH: begin
        flush_en_o = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // flush counter and registers
  //////////////////////////////////////////////////

  assign flush_done  = (flush_cnt_q == set_idx_t'(NUM_SETS - 1));
  assign flush_set_o = flush_cnt_q;
  assign cmp_en_o    = cmp_en_q;
  assign cache_en_o  = cache_en_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q     <= IDLE;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      cmp_en_q    <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q    <= state_d;
      cache_en_q <= cache_en_d;
      flush_q    <= flush_d;
      cmp_en_q   <= cmp_en_d;
      // wraps to zero after the last set
      if (flush_en_o) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/icache_arrays.sv */
// instruction cache storage
// tag, valid and line arrays for both ways, synchronous read port
`timescale 1ns/1ps
`default_nettype none

module icache_arrays import icache_cfg_pkg::*, icache_mem_pkg::*; (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  rd_en_i,
  input  wire set_idx_t              rd_set_i,
  input  wire logic                  wr_en_i,
  input  wire set_idx_t              wr_set_i,
  input  wire way_vec_t              wr_way_oh_i,
  input  wire tag_t                  wr_tag_i,
  input  wire line_t                 wr_line_i,
  input  wire logic                  inv_en_i,
  input  wire inv_t                  inv_i,
  input  wire logic                  flush_en_i,
  input  wire set_idx_t              flush_set_i,
  output tag_t  [NUM_WAYS-1:0]       rd_tags_o,
  output line_t [NUM_WAYS-1:0]       rd_lines_o,
  output way_vec_t                   rd_valid_o
);

  tag_t                      tag_mem  [NUM_WAYS][NUM_SETS];
  line_t                     line_mem [NUM_WAYS][NUM_SETS];
  way_vec_t [NUM_SETS-1:0]   valid_q;

  // valid bits: flush wins over invalidation, then refill
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
    if (!rst_ni) begin
      valid_q    <= '0;
      rd_valid_o <= '0;
    end else begin
      if (flush_en_i) begin
        valid_q[flush_set_i] <= '0;
      end else if (inv_en_i && inv_i.all) begin
        valid_q[inv_i.idx] <= '0;
      end else if (inv_en_i && inv_i.vld) begin
        valid_q[inv_i.idx][inv_i.way] <= 1'b0;
      end else if (wr_en_i) begin
        valid_q[wr_set_i] <= valid_q[wr_set_i] | wr_way_oh_i;
      end
      if (rd_en_i) begin
        rd_valid_o <= valid_q[rd_set_i];
      end
    end
  end

  // tag and line storage, per way
  always_ff @(posedge clk_i) begin : p_mem
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (wr_en_i && wr_way_oh_i[w]) begin
        tag_mem[w][wr_set_i]  <= wr_tag_i;
        line_mem[w][wr_set_i] <= wr_line_i;
      end
      // registered read, holds while rd_en is low
      if (rd_en_i) begin
        rd_tags_o[w]  <= tag_mem[w][rd_set_i];
        rd_lines_o[w] <= line_mem[w][rd_set_i];
      end
    end
  end

endmodule

`default_nettype wire

/* src/icache_repl.sv */
// instruction cache replacement
// first invalid way, else a pseudo-random way from an 8-bit lfsr
`timescale 1ns/1ps
`default_nettype none

module icache_repl import icache_cfg_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire way_vec_t valid_i,
  input  wire logic     cmp_en_i,
  input  wire logic     wr_en_i,
  output way_idx_t      repl_way_o,
  output way_vec_t      repl_way_oh_o
);

  logic [7:0] lfsr_q;
  logic       all_valid;
  way_idx_t   inv_way;
  way_idx_t   pick_way;
  way_vec_t   pick_oh;
  way_vec_t   repl_oh_q;

  // lowest invalid way
  assign all_valid = &valid_i;
  assign inv_way   = valid_i[0] ? way_idx_t'(1'b1) : way_idx_t'(1'b0);
  assign pick_way  = all_valid ? way_idx_t'(lfsr_q[0]) : inv_way;
  assign pick_oh   = way_vec_t'(1) << pick_way;

  // x^8 + x^6 + x^5 + x^4 + 1, steps only when a valid line is evicted
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lfsr
    if (!rst_ni) begin
      lfsr_q    <= LFSR_SEED;
      repl_oh_q <= way_vec_t'(1);
    end else begin
      if (wr_en_i && all_valid) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      end
      // hold the choice through the miss
      if (cmp_en_i) begin
        repl_oh_q <= pick_oh;
      end
    end
  end

  assign repl_way_oh_o = repl_oh_q;
  assign repl_way_o    = way_idx_t'(repl_oh_q[1]);

endmodule

`default_nettype wire

/* src/icache_fetch_out.sv */
// instruction cache output side
// tag compare, word select and fill request forming
`timescale 1ns/1ps
`default_nettype none

module icache_fetch_out import icache_cfg_pkg::*, icache_mem_pkg::*; (
  input  wire logic                  cmp_en_i,
  input  wire tag_t                  tag_i,
  input  wire word_off_t             off_i,
  input  wire logic                  nc_i,
  input  wire set_idx_t              addr_set_i,
  input  wire way_idx_t              repl_way_i,
  input  wire tag_t  [NUM_WAYS-1:0]  rd_tags_i,
  input  wire line_t [NUM_WAYS-1:0]  rd_lines_i,
  input  wire way_vec_t              rd_valid_i,
  input  wire mem_rtrn_t             rtrn_i,
  output logic                       hit_o,
  output fetch_word_t                data_o,
  output fill_req_t                  fill_o
);

  way_vec_t    hit_vec;
  way_idx_t    hit_way;
  fetch_word_t hit_word;
  fetch_word_t rtrn_word;

  // per way compare
  always_comb begin : p_cmp
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = rd_valid_i[w] & (rd_tags_i[w] == tag_i);
    end
  end

  // nc accesses never hit
  assign hit_o   = cmp_en_i & ~nc_i & (|hit_vec);
  assign hit_way = way_idx_t'(hit_vec[1]);

  // word from the hit line, or from the returned line
  assign hit_word  = rd_lines_i[hit_way][{off_i, 5'b0} +: 32];
  assign rtrn_word = rtrn_i.data[{off_i, 5'b0} +: 32];
  assign data_o    = cmp_en_i ? hit_word : rtrn_word;

  // word address for nc, line address otherwise
  assign fill_o.paddr = nc_i ? {tag_i, addr_set_i, off_i, 2'b00} : {tag_i, addr_set_i, 4'b0000};
  assign fill_o.nc    = nc_i;
  assign fill_o.way   = repl_way_i;

endmodule

`default_nettype wire

/* src/icache_top.sv */
// instruction cache top level
// two-way, sixteen-set cache with single-beat line refill
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_cfg_pkg::*, icache_mem_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire logic      en_i,
  input  wire logic      flush_i,
  input  wire logic      fetch_req_i,
  input  wire paddr_t    fetch_addr_i,
  input  wire logic      fill_ack_i,
  input  wire logic      rtrn_vld_i,
  input  wire mem_rtrn_t rtrn_i,
  output logic           fetch_ready_o,
  output logic           fetch_valid_o,
  output fetch_word_t    fetch_data_o,
  output logic           fill_req_o,
  output fill_req_t      fill_o,
  output logic           miss_o
);

  // address fields
  tag_t      tag;
  set_idx_t  set;
  set_idx_t  rd_set;
  word_off_t off;
  logic      nc;

  // control
  logic      rd_en;
  logic      wr_en;
  logic      inv_en;
  logic      flush_en;
  set_idx_t  flush_set;
  logic      cmp_en;
  logic      cache_en;
  logic      hit;

  // array read data and replacement
  tag_t  [NUM_WAYS-1:0] rd_tags;
  line_t [NUM_WAYS-1:0] rd_lines;
  way_vec_t             rd_valid;
  way_idx_t             repl_way;
  way_vec_t             repl_way_oh;

  icache_fetch_in i_fetch_in (
    .clk_i      ( clk_i         ),
    .rst_ni     ( rst_ni        ),
    .req_i      ( fetch_req_i   ),
    .ready_i    ( fetch_ready_o ),
    .addr_i     ( fetch_addr_i  ),
    .cache_en_i ( cache_en      ),
    .tag_o      ( tag           ),
    .set_o      ( set           ),
    .off_o      ( off           ),
    .nc_o       ( nc            ),
    .rd_set_o   ( rd_set        )
  );

  icache_ctrl i_ctrl (
    .clk_i       ( clk_i         ),
    .rst_ni      ( rst_ni        ),
    .en_i        ( en_i          ),
    .flush_i     ( flush_i       ),
    .req_i       ( fetch_req_i   ),
    .hit_i       ( hit           ),
    .nc_i        ( nc            ),
    .fill_ack_i  ( fill_ack_i    ),
    .rtrn_vld_i  ( rtrn_vld_i    ),
    .rtrn_kind_i ( rtrn_i.kind   ),
    .ready_o     ( fetch_ready_o ),
    .valid_o     ( fetch_valid_o ),
    .fill_req_o  ( fill_req_o    ),
    .miss_o      ( miss_o        ),
    .rd_en_o     ( rd_en         ),
    .wr_en_o     ( wr_en         ),
    .inv_en_o    ( inv_en        ),
    .flush_en_o  ( flush_en      ),
    .flush_set_o ( flush_set     ),
    .cmp_en_o    ( cmp_en        ),
    .cache_en_o  ( cache_en      )
  );

  icache_arrays i_arrays (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rd_en_i     ( rd_en       ),
    .rd_set_i    ( rd_set      ),
    .wr_en_i     ( wr_en       ),
    .wr_set_i    ( set         ),
    .wr_way_oh_i ( repl_way_oh ),
    .wr_tag_i    ( tag         ),
    .wr_line_i   ( rtrn_i.data ),
    .inv_en_i    ( inv_en      ),
    .inv_i       ( rtrn_i.inv  ),
    .flush_en_i  ( flush_en    ),
    .flush_set_i ( flush_set   ),
    .rd_tags_o   ( rd_tags     ),
    .rd_lines_o  ( rd_lines    ),
    .rd_valid_o  ( rd_valid    )
  );

  icache_repl i_repl (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .valid_i       ( rd_valid    ),
    .cmp_en_i      ( cmp_en      ),
    .wr_en_i       ( wr_en       ),
    .repl_way_o    ( repl_way    ),
    .repl_way_oh_o ( repl_way_oh )
  );

  icache_fetch_out i_fetch_out (
    .cmp_en_i   ( cmp_en       ),
    .tag_i      ( tag          ),
    .off_i      ( off          ),
    .nc_i       ( nc           ),
    .addr_set_i ( set          ),
    .repl_way_i ( repl_way     ),
    .rd_tags_i  ( rd_tags      ),
    .rd_lines_i ( rd_lines     ),
    .rd_valid_i ( rd_valid     ),
    .rtrn_i     ( rtrn_i       ),
    .hit_o      ( hit          ),
    .data_o     ( fetch_data_o ),
    .fill_o     ( fill_o       )
  );

endmodule

`default_nettype wire

/* tb/tb_icache.sv */
// instruction cache testbench
// memory model with random fill latency, table of fetch, flush, invalidate and enable steps
`timescale 1ns/1ps
`default_nettype none

module tb_icache import icache_cfg_pkg::*, icache_mem_pkg::*; ();

  localparam int unsigned CLK_PERIOD = 8;
  localparam int unsigned WAIT_LIMIT = 100;
  localparam int unsigned ROW_CYCLES = 200;
  localparam fetch_word_t DATA_MASK  = 32'hC0DE_0000;

  typedef enum logic [2:0] {
    OP_FETCH,
    OP_FLUSH,
    OP_INV_WAY,
    OP_INV_ALL,
    OP_ENABLE,
    OP_EVICT
  } op_e;

  // one table step with its expected values
  typedef struct packed {
    op_e         op;
    paddr_t      addr;
    logic        way;
    logic        exp_miss;
    logic        exp_fill;
    logic        exp_nc;
    fetch_word_t exp_data;
  } row_t;

  logic        clk_i;
  logic        rst_ni;
  logic        en_i;
  logic        flush_i;
  logic        fetch_req_i;
  paddr_t      fetch_addr_i;
  logic        fill_ack_i;
  logic        rtrn_vld_i;
  mem_rtrn_t   rtrn_i;
  logic        fetch_ready_o;
  logic        fetch_valid_o;
  fetch_word_t fetch_data_o;
  logic        fill_req_o;
  fill_req_t   fill_o;
  logic        miss_o;

  row_t        table_q[$];
  int unsigned num_rows;
  int unsigned errors;
  int unsigned checks;
  integer      seed;

  // memory model bookkeeping
  int unsigned fill_cnt;
  logic        fill_nc_q[$];
  way_idx_t    fill_way_q[$];
  inv_t        inv_pkt;
  int unsigned inv_req_cnt;
  int unsigned inv_done_cnt;

  icache_top UUT (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .en_i          ( en_i          ),
    .flush_i       ( flush_i       ),
    .fetch_req_i   ( fetch_req_i   ),
    .fetch_addr_i  ( fetch_addr_i  ),
    .fill_ack_i    ( fill_ack_i    ),
    .rtrn_vld_i    ( rtrn_vld_i    ),
    .rtrn_i        ( rtrn_i        ),
    .fetch_ready_o ( fetch_ready_o ),
    .fetch_valid_o ( fetch_valid_o ),
    .fetch_data_o  ( fetch_data_o  ),
    .fill_req_o    ( fill_req_o    ),
    .fill_o        ( fill_o        ),
    .miss_o        ( miss_o        )
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  // memory content is the byte address xor a fixed mask
  function automatic fetch_word_t expected_word(input paddr_t addr);
    return {addr[31:2], 2'b00} ^ DATA_MASK;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic add_row(input op_e op, input paddr_t addr, input logic way,
                         input logic exp_miss, input logic exp_fill, input logic exp_nc);
    row_t row;
    row.op       = op;
    row.addr     = addr;
    row.way      = way;
    row.exp_miss = exp_miss;
    row.exp_fill = exp_fill;
    row.exp_nc   = exp_nc;
    row.exp_data = expected_word(addr);
    table_q.push_back(row);
  endtask

  //////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////

  initial begin : mem_model
    int unsigned ack_dly;
    int unsigned rtrn_dly;
    fill_req_t   req;
    line_t       line;
    fill_ack_i = 1'b0;
    rtrn_vld_i = 1'b0;
    rtrn_i     = '0;
    forever begin
      @(posedge clk_i);
      #1;
      if (fill_req_o) begin
        req = fill_o;
        fill_cnt++;
        fill_nc_q.push_back(req.nc);
        fill_way_q.push_back(req.way);
        // acknowledge after 0..3 cycles
        ack_dly = $unsigned($random(seed)) % 32'd4;
        repeat (ack_dly) begin
          @(posedge clk_i);
          #1;
        end
        fill_ack_i = 1'b1;
        @(posedge clk_i);
        #1;
        fill_ack_i = 1'b0;
        // line comes back 1..4 cycles after the ack
        rtrn_dly = $unsigned($random(seed)) % 32'd4;
        repeat (rtrn_dly) begin
          @(posedge clk_i);
          #1;
        end
        for (int i = 0; i < 4; i++) begin
          if (req.nc) begin
            line[32*i +: 32] = expected_word(req.paddr);
          end else begin
            line[32*i +: 32] = expected_word(req.paddr + paddr_t'(4 * i));
          end
        end
        rtrn_i.kind = IFILL_ACK;
        rtrn_i.data = line;
        rtrn_i.inv  = '0;
        rtrn_vld_i  = 1'b1;
        @(posedge clk_i);
        #1;
        rtrn_vld_i  = 1'b0;
      end else if (inv_done_cnt != inv_req_cnt) begin
        rtrn_i.kind = INV_REQ;
        rtrn_i.inv  = inv_pkt;
        rtrn_vld_i  = 1'b1;
        @(posedge clk_i);
        #1;
        rtrn_vld_i  = 1'b0;
        inv_done_cnt++;
      end
    end
  end

  //////////////////////////////////////////////////
  // operations enter and leave 1 ns after a rising edge
  //////////////////////////////////////////////////

  task automatic run_fetch(input paddr_t addr, input logic exp_miss, input logic exp_fill,
                           input logic exp_nc, input fetch_word_t exp_data);
    int unsigned cycles;
    int unsigned fills_before;
    logic        accepted;
    logic        got_valid;
    logic        seen_miss;
    fetch_word_t data;
    fills_before = fill_cnt;
    accepted     = 1'b0;
    got_valid    = 1'b0;
    seen_miss    = 1'b0;
    data         = '0;
    cycles       = 0;
    fetch_addr_i = addr;
    fetch_req_i  = 1'b1;
    while (!accepted && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      accepted = fetch_ready_o;
      cycles++;
      @(posedge clk_i);
      #1;
    end
    fetch_req_i = 1'b0;
    if (!accepted) begin
      errors++;
      $display("fetch of %h was never accepted at t=%0t", addr, $time);
      return;
    end
    // cycles counted from the accept edge
    cycles = 0;
    while (!got_valid && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
      seen_miss = seen_miss | miss_o;
      if (fetch_valid_o) begin
        got_valid = 1'b1;
        data      = fetch_data_o;
      end
      @(posedge clk_i);
      #1;
    end
    if (!got_valid) begin
      errors++;
      $display("fetch of %h never returned valid data at t=%0t", addr, $time);
      return;
    end
    check_eq("fetch_data_o", data, exp_data);
    check_eq("miss_o", 32'(seen_miss), 32'(exp_miss));
    check_eq("fill_count", fill_cnt - fills_before, 32'(exp_fill));
    if (exp_fill && fill_cnt != fills_before) begin
      check_eq("fill_o.nc", 32'(fill_nc_q[$]), 32'(exp_nc));
    end
    if (!exp_fill) begin
      check_eq("hit_latency", cycles, 32'd1);
    end
  endtask

  // count the cycles with ready low after a flush trigger
  task automatic wait_flush();
    int unsigned low_cycles;
    logic        ready;
    low_cycles = 0;
    ready      = 1'b0;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    while (!ready && low_cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      ready = fetch_ready_o;
      if (!ready) begin
        low_cycles++;
      end
      @(posedge clk_i);
      #1;
    end
    check_eq("flush_cycles", low_cycles, NUM_SETS);
  endtask

  task automatic send_inv(input paddr_t addr, input logic way, input logic all);
    int unsigned cycles;
    cycles      = 0;
    inv_pkt.idx = addr[7:4];
    inv_pkt.way = way;
    inv_pkt.vld = ~all;
    inv_pkt.all = all;
    inv_req_cnt++;
    while (inv_done_cnt != inv_req_cnt && cycles < WAIT_LIMIT) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (inv_done_cnt != inv_req_cnt) begin
      errors++;
      $display("invalidation of set %0d was never sent at t=%0t", addr[7:4], $time);
    end
  endtask

  // way 0 holds addr, way 1 holds addr + 0x1000; the last fill names the victim
  task automatic check_evict(input paddr_t addr);
    paddr_t   other;
    way_idx_t victim;
    other  = addr + 32'h1000;
    victim = fill_way_q[$];
    if (victim == 1'b0) begin
      run_fetch(other, 1'b0, 1'b0, 1'b0, expected_word(other));
      run_fetch(addr, 1'b1, 1'b1, 1'b0, expected_word(addr));
    end else begin
      run_fetch(addr, 1'b0, 1'b0, 1'b0, expected_word(addr));
      run_fetch(other, 1'b1, 1'b1, 1'b0, expected_word(other));
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus table and main sequence
  //////////////////////////////////////////////////

  initial begin : watchdog
    wait (num_rows > 0);
    #(num_rows * ROW_CYCLES * CLK_PERIOD);
    $display("timeout, the test did not finish in time");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin : main
    seed         = 83163;
    errors       = 0;
    checks       = 0;
    fill_cnt     = 0;
    inv_req_cnt  = 0;
    inv_done_cnt = 0;
    inv_pkt      = '0;
    num_rows     = 0;
    rst_ni       = 1'b0;
    en_i         = 1'b0;
    flush_i      = 1'b0;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;

    // op, address, way, miss, fill, nc
    add_row(OP_ENABLE,  32'h1,         1'b0, 1'b0, 1'b0, 1'b0);
    add_row(OP_FETCH,   32'h0000_1040, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row(OP_FETCH,   32'h0000_1048, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(OP_FETCH,   32'h8000_0104, 1'b0, 1'b0, 1'b1, 1'b1);
    add_row(OP_FETCH,   32'h8000_0104, 1'b0, 1'b0, 1'b1, 1'b1);
    add_row(OP_ENABLE,  32'h0,         1'b0, 1'b0, 1'b0, 1'b0);
    add_row(OP_FETCH,   32'h0000_1044, 1'b0, 1'b0, 1'b1, 1'b1);
    add_row(OP_ENABLE,  32'h1,         1'b0, 1'b0, 1'b0, 1'b0);
    add_row(OP_FETCH,   32'h0000_1040, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row(OP_FETCH,   32'h0000_2020, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row(OP_FETCH,   32'h0000_3030, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row(OP_INV_WAY, 32'h0000_2020, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(OP_FETCH,   32'h0000_202C, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row(OP_FETCH,   32'h0000_3034, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(OP_INV_ALL, 32'h0000_3030, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(OP_FETCH,   32'h0000_3038, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row(OP_FETCH,   32'h0000_2024, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(OP_FLUSH,   32'h0,         1'b0, 1'b0, 1'b0, 1'b0);
    add_row(OP_FETCH,   32'h0000_1040, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row(OP_FETCH,   32'h0000_3030, 1'b0, 1'b1, 1'b1, 1'b0);
    // three tags in set 5
    add_row(OP_FETCH,   32'h0000_4050, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row(OP_FETCH,   32'h0000_5050, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row(OP_FETCH,   32'h0000_6058, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row(OP_EVICT,   32'h0000_4050, 1'b0, 1'b0, 1'b0, 1'b0);

    repeat (8) @(posedge clk_i);
    #1;
    rst_ni   = 1'b1;
    num_rows = table_q.size();

    foreach (table_q[i]) begin
      unique case (table_q[i].op)
        OP_FETCH: begin
          run_fetch(table_q[i].addr, table_q[i].exp_miss, table_q[i].exp_fill,
                    table_q[i].exp_nc, table_q[i].exp_data);
        end
        OP_FLUSH: begin
          flush_i = 1'b1;
          wait_flush();
        end
        OP_INV_WAY: begin
          send_inv(table_q[i].addr, table_q[i].way, 1'b0);
        end
        OP_INV_ALL: begin
          send_inv(table_q[i].addr, 1'b0, 1'b1);
        end
        OP_ENABLE: begin
          en_i = table_q[i].addr[0];
          if (table_q[i].addr[0]) begin
            wait_flush();
          end else begin
            @(posedge clk_i);
            #1;
          end
        end
        default: begin
          check_evict(table_q[i].addr);
        end
      endcase
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
src/icache_cfg_pkg.sv
src/icache_mem_pkg.sv
src/icache_fetch_in.sv
src/icache_ctrl.sv
src/icache_arrays.sv
src/icache_repl.sv
src/icache_fetch_out.sv
src/icache_top.sv
tb/tb_icache.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the instruction cache testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_icache -o tb_icache_sim --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out="$(./obj_dir/tb_icache_sim)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "RESULT: PASS" <<< "$out"; then
  exit 0
fi
exit 1
